// ==== logic/rv_decode_consts.svh ====
`ifndef RV_DECODE_CONSTS_SVH
`define RV_DECODE_CONSTS_SVH

// datapath widths
`define RV_XLEN      32
`define RV_REG_BITS  5
`define RV_CSR_BITS  12

// major opcodes, inst[6:0]
`define RV_OPC_LUI       7'b0110111
`define RV_OPC_AUIPC     7'b0010111
`define RV_OPC_JAL       7'b1101111
`define RV_OPC_JALR      7'b1100111
`define RV_OPC_BRANCH    7'b1100011
`define RV_OPC_LOAD      7'b0000011
`define RV_OPC_STORE     7'b0100011
`define RV_OPC_OP_IMM    7'b0010011
`define RV_OPC_OP        7'b0110011
`define RV_OPC_SYSTEM    7'b1110011
`define RV_OPC_MISC_MEM  7'b0001111

// funct fields
`define RV_F7_BASE     7'b0000000
`define RV_F7_ALT      7'b0100000
`define RV_F3_FENCE_I  3'b001
`define RV_F3_PRIV     3'b000
`define RV_F3_CSRRW    3'b001
`define RV_F3_CSRRS    3'b010
`define RV_F3_CSRRC    3'b011

// whole-word system encodings
`define RV_INST_ECALL   32'h00000073
`define RV_INST_EBREAK  32'h00100073
`define RV_INST_MRET    32'h30200073

`endif

// ==== logic/rv_decode_pkg.sv ====
`include "rv_decode_consts.svh"

package rv_decode_pkg;

  // alu operation, the branch compares share the alu
  typedef enum logic [4:0] {
    add,
    sub,
    xor_op,
    or_op,
    and_op,
    sll,
    srl,
    sra,
    slt,
    sltu,
    beq,
    bne,
    blt,
    bge,
    bltu,
    bgeu,
    csr_set,
    csr_clear
  } alu_op_e;

  typedef enum logic [1:0] {
    seq,
    jal,
    jalr,
    branch
  } next_pc_e;

  // register write data source in EX
  typedef enum logic [1:0] {
    alu,
    link,
    auipc_sum,
    csr_old
  } wb_src_e;

  typedef enum logic [1:0] {
    reg_op,
    imm,
    csr
  } op2_src_e;

  // both bits may be set, the consumer gives EX priority
  typedef struct packed {
    logic from_ex;
    logic from_ls;
  } fwd_sel_t;

  typedef struct packed {
    logic ren;
    logic wen;
    logic byte_acc;
    logic half_acc;
    logic sext;
  } mem_ctrl_t;

  // one-hot immediate format
  typedef struct packed {
    logic u;
    logic j;
    logic b;
    logic i;
    logic s;
  } imm_fmt_t;

  typedef struct packed {
    alu_op_e                 alu_op;
    next_pc_e                next_pc;
    wb_src_e                 wb_src;
    op2_src_e                op2_src;
    logic [`RV_REG_BITS-1:0] rs1;
    logic [`RV_REG_BITS-1:0] rs2;
    logic [`RV_REG_BITS-1:0] rd;
    logic                    rd_wen;
    logic [`RV_CSR_BITS-1:0] csr_addr;
    logic                    csr_inst;
    mem_ctrl_t               mem;
    logic                    is_ecall;
    logic                    is_mret;
    logic                    is_fence_i;
    // pads the bundle to 64 bits, always zero
    logic [15:0]             spare;
  } decode_ctrl_t;

endpackage

// ==== logic/imm_gen.sv ====
`timescale 1ns/1ps
`include "rv_decode_consts.svh"

module imm_gen (
  input  logic [`RV_XLEN-1:0]    inst_q,
  input  rv_decode_pkg::imm_fmt_t fmt,
  output logic [`RV_XLEN-1:0]    imm
);

  logic [`RV_XLEN-1:0] u_imm;
  logic [`RV_XLEN-1:0] j_imm;
  logic [`RV_XLEN-1:0] b_imm;
  logic [`RV_XLEN-1:0] i_imm;
  logic [`RV_XLEN-1:0] s_imm;

  // upper 20 bits, low half zero
  assign u_imm = {inst_q[31:12], 12'b0};

  // jump offset, bit 0 implied
  assign j_imm = {{12{inst_q[31]}}, inst_q[19:12], inst_q[20],
                  inst_q[30:25], inst_q[24:21], 1'b0};

  // branch offset, bit 0 implied
  assign b_imm = {{20{inst_q[31]}}, inst_q[7], inst_q[30:25],
                  inst_q[11:8], 1'b0};

  assign i_imm = {{20{inst_q[31]}}, inst_q[31:20]};

  // store offset is split around rd's slot
  assign s_imm = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};

  // fmt is one-hot, so the masked terms never overlap
  assign imm = ({`RV_XLEN{fmt.u}} & u_imm) |
               ({`RV_XLEN{fmt.j}} & j_imm) |
               ({`RV_XLEN{fmt.b}} & b_imm) |
               ({`RV_XLEN{fmt.i}} & i_imm) |
               ({`RV_XLEN{fmt.s}} & s_imm);

endmodule

// ==== logic/inst_field_decoder.sv ====
`timescale 1ns/1ps
`include "rv_decode_consts.svh"

module inst_field_decoder (
  input  logic [`RV_XLEN-1:0]        inst_q,
  output rv_decode_pkg::decode_ctrl_t ctrl,
  output logic [`RV_XLEN-1:0]        imm
);

  logic [6:0]              opcode;
  logic [2:0]              funct3;
  logic [6:0]              funct7;
  logic                    legal;
  rv_decode_pkg::imm_fmt_t fmt;

  assign opcode = inst_q[6:0];
  assign funct3 = inst_q[14:12];
  assign funct7 = inst_q[31:25];

  imm_gen imm_gen_i (
    .inst_q (inst_q),
    .fmt    (fmt),
    .imm    (imm)
  );

  always_comb begin
    ctrl  = '0;
    fmt   = '0;
    legal = 1'b0;
    case (opcode)
      `RV_OPC_LUI: begin
        legal        = 1'b1;
        fmt.u        = 1'b1;
        ctrl.op2_src = rv_decode_pkg::imm;
        ctrl.rd_wen  = 1'b1;
      end
      `RV_OPC_AUIPC: begin
        legal       = 1'b1;
        fmt.u       = 1'b1;
        ctrl.wb_src = rv_decode_pkg::auipc_sum;
        ctrl.rd_wen = 1'b1;
      end
      `RV_OPC_JAL: begin
        legal        = 1'b1;
        fmt.j        = 1'b1;
        ctrl.next_pc = rv_decode_pkg::jal;
        ctrl.wb_src  = rv_decode_pkg::link;
        ctrl.rd_wen  = 1'b1;
      end
      `RV_OPC_JALR: begin
        legal        = (funct3 == 3'b000);
        fmt.i        = 1'b1;
        ctrl.next_pc = rv_decode_pkg::jalr;
        ctrl.wb_src  = rv_decode_pkg::link;
        ctrl.op2_src = rv_decode_pkg::imm;
        ctrl.rd_wen  = 1'b1;
      end
      `RV_OPC_BRANCH: begin
        legal        = 1'b1;
        fmt.b        = 1'b1;
        ctrl.next_pc = rv_decode_pkg::branch;
        case (funct3)
          3'b000:  ctrl.alu_op = rv_decode_pkg::beq;
          3'b001:  ctrl.alu_op = rv_decode_pkg::bne;
          3'b100:  ctrl.alu_op = rv_decode_pkg::blt;
          3'b101:  ctrl.alu_op = rv_decode_pkg::bge;
          3'b110:  ctrl.alu_op = rv_decode_pkg::bltu;
          3'b111:  ctrl.alu_op = rv_decode_pkg::bgeu;
          default: legal = 1'b0;
        endcase
      end
      `RV_OPC_LOAD: begin
        legal             = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
        fmt.i             = 1'b1;
        ctrl.op2_src      = rv_decode_pkg::imm;
        ctrl.rd_wen       = 1'b1;
        ctrl.mem.ren      = 1'b1;
        ctrl.mem.byte_acc = (funct3[1:0] == 2'b00);
        ctrl.mem.half_acc = (funct3[1:0] == 2'b01);
        // only lb and lh extend, lw fills the word anyway
        ctrl.mem.sext     = ~funct3[2] & ~funct3[1];
      end
      `RV_OPC_STORE: begin
        legal             = funct3 inside {3'b000, 3'b001, 3'b010};
        fmt.s             = 1'b1;
        ctrl.op2_src      = rv_decode_pkg::imm;
        ctrl.mem.wen      = 1'b1;
        ctrl.mem.byte_acc = (funct3[1:0] == 2'b00);
        ctrl.mem.half_acc = (funct3[1:0] == 2'b01);
      end
      `RV_OPC_OP_IMM: begin
        legal        = 1'b1;
        fmt.i        = 1'b1;
        ctrl.op2_src = rv_decode_pkg::imm;
        ctrl.rd_wen  = 1'b1;
        case (funct3)
          3'b000: ctrl.alu_op = rv_decode_pkg::add;
          3'b010: ctrl.alu_op = rv_decode_pkg::slt;
          3'b011: ctrl.alu_op = rv_decode_pkg::sltu;
          3'b100: ctrl.alu_op = rv_decode_pkg::xor_op;
          3'b110: ctrl.alu_op = rv_decode_pkg::or_op;
          3'b111: ctrl.alu_op = rv_decode_pkg::and_op;
          3'b001: begin
            ctrl.alu_op = rv_decode_pkg::sll;
            legal       = (funct7 == `RV_F7_BASE);
          end
          3'b101: begin
            ctrl.alu_op = (funct7 == `RV_F7_ALT) ? rv_decode_pkg::sra : rv_decode_pkg::srl;
            legal       = funct7 inside {`RV_F7_BASE, `RV_F7_ALT};
          end
        endcase
      end
      `RV_OPC_OP: begin
        legal       = (funct7 == `RV_F7_BASE);
        ctrl.rd_wen = 1'b1;
        case (funct3)
          3'b000: begin
            ctrl.alu_op = (funct7 == `RV_F7_ALT) ? rv_decode_pkg::sub : rv_decode_pkg::add;
            legal       = funct7 inside {`RV_F7_BASE, `RV_F7_ALT};
          end
          3'b001: ctrl.alu_op = rv_decode_pkg::sll;
          3'b010: ctrl.alu_op = rv_decode_pkg::slt;
          3'b011: ctrl.alu_op = rv_decode_pkg::sltu;
          3'b100: ctrl.alu_op = rv_decode_pkg::xor_op;
          3'b101: begin
            ctrl.alu_op = (funct7 == `RV_F7_ALT) ? rv_decode_pkg::sra : rv_decode_pkg::srl;
            legal       = funct7 inside {`RV_F7_BASE, `RV_F7_ALT};
          end
          3'b110: ctrl.alu_op = rv_decode_pkg::or_op;
          3'b111: ctrl.alu_op = rv_decode_pkg::and_op;
        endcase
      end
      `RV_OPC_SYSTEM: begin
        case (funct3)
          `RV_F3_CSRRW, `RV_F3_CSRRS, `RV_F3_CSRRC: begin
            legal         = 1'b1;
            fmt.i         = 1'b1;
            ctrl.wb_src   = rv_decode_pkg::csr_old;
            ctrl.rd_wen   = 1'b1;
            ctrl.csr_inst = 1'b1;
            // csrrw keeps add with rs2 forced to x0, so EX passes rs1 through
            if (funct3 == `RV_F3_CSRRS) begin
              ctrl.alu_op  = rv_decode_pkg::csr_set;
              ctrl.op2_src = rv_decode_pkg::csr;
            end else if (funct3 == `RV_F3_CSRRC) begin
              ctrl.alu_op  = rv_decode_pkg::csr_clear;
              ctrl.op2_src = rv_decode_pkg::csr;
            end
          end
          `RV_F3_PRIV: begin
            // ebreak is accepted but has no effect in this core
            legal           = inst_q inside {`RV_INST_ECALL, `RV_INST_MRET, `RV_INST_EBREAK};
            ctrl.is_ecall   = (inst_q == `RV_INST_ECALL);
            ctrl.is_mret    = (inst_q == `RV_INST_MRET);
          end
          default: legal = 1'b0;
        endcase
      end
      `RV_OPC_MISC_MEM: begin
        legal           = (funct3 == `RV_F3_FENCE_I);
        ctrl.is_fence_i = 1'b1;
      end
      default: legal = 1'b0;
    endcase

    if (legal) begin
      // lui reads x0 so EX computes 0 + imm
      ctrl.rs1      = (opcode == `RV_OPC_LUI) ? '0 : inst_q[19:15];
      ctrl.rs2      = (ctrl.csr_inst && funct3 == `RV_F3_CSRRW) ? '0 : inst_q[24:20];
      ctrl.rd       = ctrl.rd_wen ? inst_q[11:7] : '0;
      ctrl.csr_addr = ctrl.csr_inst ? inst_q[31:20] : '0;
    end else begin
      ctrl = '0;
      fmt  = '0;
    end
  end

endmodule

// ==== logic/hazard_tracker.sv ====
`timescale 1ns/1ps
`include "rv_decode_consts.svh"

module hazard_tracker (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    advance,
  input  logic                    flush,
  input  logic [`RV_REG_BITS-1:0] cur_rd,
  input  logic                    cur_rd_wen,
  input  logic [`RV_CSR_BITS-1:0] cur_csr,
  input  logic                    cur_csr_wen,
  input  logic                    cur_is_load,
  input  logic [`RV_REG_BITS-1:0] rs1,
  input  logic [`RV_REG_BITS-1:0] rs2,
  input  logic [`RV_CSR_BITS-1:0] csr_src,
  input  logic [`RV_REG_BITS-1:0] next_rs1,
  input  logic [`RV_REG_BITS-1:0] next_rs2,
  output rv_decode_pkg::fwd_sel_t fwd_rs1,
  output rv_decode_pkg::fwd_sel_t fwd_rs2,
  output rv_decode_pkg::fwd_sel_t fwd_csr,
  output logic [`RV_REG_BITS-1:0] wb_rd,
  output logic                    wb_rd_wen,
  output logic [`RV_CSR_BITS-1:0] wb_csr,
  output logic                    wb_csr_wen,
  output logic                    ready
);

  typedef struct packed {
    logic [`RV_REG_BITS-1:0] rd;
    logic                    rd_wen;
    logic [`RV_CSR_BITS-1:0] csr;
    logic                    csr_wen;
  } dest_t;

  // ex_q tracks the instruction now in EX, ls_q the one in LS
  dest_t ex_q;
  dest_t ls_q;

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      ex_q.rd_wen  <= 1'b0;
      ex_q.csr_wen <= 1'b0;
      ls_q.rd_wen  <= 1'b0;
      ls_q.csr_wen <= 1'b0;
    end else if (advance) begin
      ex_q.rd      <= cur_rd;
      ex_q.rd_wen  <= cur_rd_wen;
      ex_q.csr     <= cur_csr;
      ex_q.csr_wen <= cur_csr_wen;
      ls_q         <= ex_q;
    end
  end

  assign wb_rd      = ls_q.rd;
  assign wb_rd_wen  = ls_q.rd_wen;
  assign wb_csr     = ls_q.csr;
  assign wb_csr_wen = ls_q.csr_wen;

  // x0 never forwards
  assign fwd_rs1.from_ex = ex_q.rd_wen && (ex_q.rd != '0) && (rs1 == ex_q.rd);
  assign fwd_rs1.from_ls = ls_q.rd_wen && (ls_q.rd != '0) && (rs1 == ls_q.rd);
  assign fwd_rs2.from_ex = ex_q.rd_wen && (ex_q.rd != '0) && (rs2 == ex_q.rd);
  assign fwd_rs2.from_ls = ls_q.rd_wen && (ls_q.rd != '0) && (rs2 == ls_q.rd);

  // a csr source only counts when the consumer is itself a csr access
  assign fwd_csr.from_ex = cur_csr_wen && ex_q.csr_wen && (csr_src == ex_q.csr);
  assign fwd_csr.from_ls = cur_csr_wen && ls_q.csr_wen && (csr_src == ls_q.csr);

  // load data is not back until LS, so a dependent word must wait one cycle
  assign ready = !(cur_is_load && (cur_rd != '0) &&
                   ((next_rs1 == cur_rd) || (next_rs2 == cur_rd)));

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps
`include "rv_decode_consts.svh"

module decode_stage (
  input  logic                        clock,
  input  logic                        reset,
  input  logic [`RV_XLEN-1:0]         inst,
  input  logic [`RV_XLEN-1:0]         pc,
  input  logic                        inst_valid,
  input  logic                        block,
  input  logic                        clear_pipeline,
  output logic                        ready,
  output logic                        decode_valid,
  output logic [`RV_XLEN-1:0]         pc_out,
  output rv_decode_pkg::decode_ctrl_t ctrl_out,
  output logic [`RV_XLEN-1:0]         imm,
  output rv_decode_pkg::fwd_sel_t     fwd_rs1,
  output rv_decode_pkg::fwd_sel_t     fwd_rs2,
  output rv_decode_pkg::fwd_sel_t     fwd_csr,
  output rv_decode_pkg::mem_ctrl_t    mem,
  output logic [`RV_REG_BITS-1:0]     wb_rd,
  output logic                        wb_rd_wen,
  output logic [`RV_CSR_BITS-1:0]     wb_csr,
  output logic                        wb_csr_wen,
  output logic                        ecall,
  output logic                        mret,
  output logic                        fence_i
);

  logic [`RV_XLEN-1:0]         inst_q;
  logic [`RV_XLEN-1:0]         pc_q;
  rv_decode_pkg::decode_ctrl_t ctrl;
  logic                        advance;
  logic                        capture;
  // {ecall, mret, fence_i} at ID, then one and two edges later
  logic [2:0]                  sys_now;
  logic [2:0]                  sys_d1;
  logic [2:0]                  sys_d2;

  assign advance = !block;
  assign capture = inst_valid && ready && advance && !clear_pipeline;

  assign ctrl_out = ctrl;
  assign sys_now  = {ctrl.is_ecall, ctrl.is_mret, ctrl.is_fence_i};
  assign {ecall, mret, fence_i} = sys_d2;

  inst_field_decoder inst_field_decoder_i (
    .inst_q (inst_q),
    .ctrl   (ctrl),
    .imm    (imm)
  );

  hazard_tracker hazard_tracker_i (
    .clock       (clock),
    .reset       (reset),
    .advance     (advance),
    .flush       (clear_pipeline),
    .cur_rd      (ctrl.rd),
    .cur_rd_wen  (ctrl.rd_wen),
    .cur_csr     (ctrl.csr_addr),
    .cur_csr_wen (ctrl.csr_inst),
    .cur_is_load (ctrl.mem.ren),
    .rs1         (ctrl.rs1),
    .rs2         (ctrl.rs2),
    .csr_src     (ctrl.csr_addr),
    .next_rs1    (inst[19:15]),
    .next_rs2    (inst[24:20]),
    .fwd_rs1     (fwd_rs1),
    .fwd_rs2     (fwd_rs2),
    .fwd_csr     (fwd_csr),
    .wb_rd       (wb_rd),
    .wb_rd_wen   (wb_rd_wen),
    .wb_csr      (wb_csr),
    .wb_csr_wen  (wb_csr_wen),
    .ready       (ready)
  );

  // flush beats block, block freezes everything else
  always_ff @(posedge clock) begin
    if (reset || clear_pipeline) begin
      inst_q       <= '0;
      decode_valid <= 1'b0;
      mem          <= '0;
      sys_d1       <= '0;
      sys_d2       <= '0;
    end else if (advance) begin
      // a stall or an empty fetch slot becomes an all-zero bubble
      inst_q       <= capture ? inst : '0;
      decode_valid <= capture;
      mem          <= ctrl.mem;
      sys_d1       <= sys_now;
      sys_d2       <= sys_d1;
    end
  end

  // pc_q is paired with inst_q, pc_out lines up with mem in EX
  always_ff @(posedge clock) begin
    if (advance) begin
      pc_q   <= pc;
      pc_out <= pc_q;
    end
  end

endmodule

// ==== logic/decode_top.sv ====
`timescale 1ns/1ps
`include "rv_decode_consts.svh"

module decode_top (
  input  logic                        clock,
  input  logic                        reset,
  input  logic [`RV_XLEN-1:0]         inst,
  input  logic [`RV_XLEN-1:0]         pc,
  input  logic                        inst_valid,
  input  logic                        block,
  input  logic                        clear_pipeline,
  output logic                        ready,
  output logic                        decode_valid,
  output logic [`RV_XLEN-1:0]         pc_out,
  output rv_decode_pkg::decode_ctrl_t ctrl_out,
  output logic [`RV_XLEN-1:0]         imm,
  output rv_decode_pkg::fwd_sel_t     fwd_rs1,
  output rv_decode_pkg::fwd_sel_t     fwd_rs2,
  output rv_decode_pkg::fwd_sel_t     fwd_csr,
  output rv_decode_pkg::mem_ctrl_t    mem,
  output logic [`RV_REG_BITS-1:0]     wb_rd,
  output logic                        wb_rd_wen,
  output logic [`RV_CSR_BITS-1:0]     wb_csr,
  output logic                        wb_csr_wen,
  output logic                        ecall,
  output logic                        mret,
  output logic                        fence_i
);

  // port names match one to one
  decode_stage decode_stage_i (.*);

endmodule

// ==== tests/decode_asserts.sv ====
`timescale 1ns/1ps
`include "rv_decode_consts.svh"

module decode_asserts (
  input logic                        clock,
  input logic                        reset,
  input logic                        block,
  input logic                        clear_pipeline,
  input logic                        ready,
  input logic                        decode_valid,
  input rv_decode_pkg::decode_ctrl_t ctrl_out,
  input logic [`RV_XLEN-1:0]         imm,
  input rv_decode_pkg::mem_ctrl_t    mem,
  input logic [`RV_REG_BITS-1:0]     wb_rd,
  input logic                        wb_rd_wen,
  input logic [`RV_CSR_BITS-1:0]     wb_csr,
  input logic                        wb_csr_wen,
  input logic                        ecall,
  input logic                        mret,
  input logic                        fence_i
);

  // a load-use stall turns the slot into a bubble on the next edge
  a_stall_bubble: assert property (@(posedge clock) disable iff (reset)
    (!ready && !block && !clear_pipeline) |=> !decode_valid)
    else $error("word captured while ready was low");

  a_ecall_pulse: assert property (@(posedge clock) disable iff (reset)
    (ecall && !block) |=> !ecall)
    else $error("ecall longer than one cycle");

  a_mret_pulse: assert property (@(posedge clock) disable iff (reset)
    (mret && !block) |=> !mret)
    else $error("mret longer than one cycle");

  a_fence_i_pulse: assert property (@(posedge clock) disable iff (reset)
    (fence_i && !block) |=> !fence_i)
    else $error("fence_i longer than one cycle");

  a_flush_clears: assert property (@(posedge clock) disable iff (reset)
    clear_pipeline |=> !(wb_rd_wen || wb_csr_wen || mem.ren || mem.wen))
    else $error("write enable active after clear_pipeline");

  // flush wins over block, so it is excluded here
  a_block_holds: assert property (@(posedge clock) disable iff (reset)
    (block && !clear_pipeline) |=>
      $stable({decode_valid, ctrl_out, imm, mem, wb_rd, wb_rd_wen, wb_csr, wb_csr_wen,
               ecall, mret, fence_i}))
    else $error("outputs moved while block was high");

endmodule

// ==== tests/decode_tb.sv ====
`timescale 1ns/1ps
`include "rv_decode_consts.svh"

module decode_tb;

  localparam int TEST_CYCLES = 400;
  localparam int NUM_TESTS   = 6;
  localparam int CYCLE_LIMIT = 2600;

  typedef struct packed {
    logic [`RV_REG_BITS-1:0] rd;
    logic                    rd_wen;
    logic [`RV_CSR_BITS-1:0] csr;
    logic                    csr_wen;
  } dest_t;

  logic                        clock;
  logic                        reset;
  logic [`RV_XLEN-1:0]         inst;
  logic [`RV_XLEN-1:0]         pc;
  logic                        inst_valid;
  logic                        block;
  logic                        clear_pipeline;
  logic                        ready;
  logic                        decode_valid;
  logic [`RV_XLEN-1:0]         pc_out;
  rv_decode_pkg::decode_ctrl_t ctrl_out;
  logic [`RV_XLEN-1:0]         imm;
  rv_decode_pkg::fwd_sel_t     fwd_rs1;
  rv_decode_pkg::fwd_sel_t     fwd_rs2;
  rv_decode_pkg::fwd_sel_t     fwd_csr;
  rv_decode_pkg::mem_ctrl_t    mem;
  logic [`RV_REG_BITS-1:0]     wb_rd;
  logic                        wb_rd_wen;
  logic [`RV_CSR_BITS-1:0]     wb_csr;
  logic                        wb_csr_wen;
  logic                        ecall;
  logic                        mret;
  logic                        fence_i;

  // model state
  logic [31:0]              m_inst;
  logic                     m_valid;
  rv_decode_pkg::mem_ctrl_t m_mem;
  logic [2:0]               m_sys1;
  logic [2:0]               m_sys2;
  dest_t                    m_ex;
  dest_t                    m_ls;
  logic [31:0]              m_pc_q;
  logic [31:0]              m_pc_out;

  logic [31:0] seed;
  int          cycles;
  int          errors;
  int          checks;
  int          stalls;
  int          p_block [NUM_TESTS] = '{0, 0, 25, 0, 15, 20};
  int          p_clear [NUM_TESTS] = '{0, 0, 0, 8, 4, 6};
  int          p_load  [NUM_TESTS] = '{0, 40, 10, 10, 20, 30};

  decode_top decode_top_i (.*);

  bind decode_top decode_asserts decode_asserts_i (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge clock);
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("** FAIL **");
        $finish;
      end
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function logic [31:0] rand32();
    seed = xorshift(seed);
    return seed;
  endfunction

  function automatic rv_decode_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    return alt ? rv_decode_pkg::sub : rv_decode_pkg::add;
      3'd1:    return rv_decode_pkg::sll;
      3'd2:    return rv_decode_pkg::slt;
      3'd3:    return rv_decode_pkg::sltu;
      3'd4:    return rv_decode_pkg::xor_op;
      3'd5:    return alt ? rv_decode_pkg::sra : rv_decode_pkg::srl;
      3'd6:    return rv_decode_pkg::or_op;
      default: return rv_decode_pkg::and_op;
    endcase
  endfunction

  // reference decode of one word, straight from the ISA field rules
  function automatic rv_decode_pkg::decode_ctrl_t predict_ctrl(input logic [31:0] w);
    rv_decode_pkg::decode_ctrl_t c;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       ok;
    c  = '0;
    f3 = w[14:12];
    f7 = w[31:25];
    ok = 1'b1;
    case (w[6:0])
      `RV_OPC_LUI: begin
        c.op2_src = rv_decode_pkg::imm;
        c.rd_wen  = 1'b1;
      end
      `RV_OPC_AUIPC: begin
        c.wb_src = rv_decode_pkg::auipc_sum;
        c.rd_wen = 1'b1;
      end
      `RV_OPC_JAL: begin
        c.next_pc = rv_decode_pkg::jal;
        c.wb_src  = rv_decode_pkg::link;
        c.rd_wen  = 1'b1;
      end
      `RV_OPC_JALR: begin
        ok        = (f3 == 3'd0);
        c.next_pc = rv_decode_pkg::jalr;
        c.wb_src  = rv_decode_pkg::link;
        c.op2_src = rv_decode_pkg::imm;
        c.rd_wen  = 1'b1;
      end
      `RV_OPC_BRANCH: begin
        ok        = (f3 != 3'd2) && (f3 != 3'd3);
        c.next_pc = rv_decode_pkg::branch;
        c.alu_op  = rv_decode_pkg::alu_op_e'(5'(rv_decode_pkg::beq) +
                                              (f3 >= 3'd4 ? f3 - 3'd2 : f3));
      end
      `RV_OPC_LOAD: begin
        ok           = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        c.op2_src    = rv_decode_pkg::imm;
        c.rd_wen     = 1'b1;
        c.mem.ren    = 1'b1;
        c.mem.byte_acc = (f3 == 3'd0) || (f3 == 3'd4);
        c.mem.half_acc = (f3 == 3'd1) || (f3 == 3'd5);
        c.mem.sext   = (f3 == 3'd0) || (f3 == 3'd1);
      end
      `RV_OPC_STORE: begin
        ok             = (f3 <= 3'd2);
        c.op2_src      = rv_decode_pkg::imm;
        c.mem.wen      = 1'b1;
        c.mem.byte_acc = (f3 == 3'd0);
        c.mem.half_acc = (f3 == 3'd1);
      end
      `RV_OPC_OP_IMM: begin
        if (f3 == 3'd1)
          ok = (f7 == 7'h00);
        else if (f3 == 3'd5)
          ok = (f7 == 7'h00) || (f7 == 7'h20);
        c.op2_src = rv_decode_pkg::imm;
        c.rd_wen  = 1'b1;
        c.alu_op  = arith_op(f3, (f3 == 3'd5) && (f7 == 7'h20));
      end
      `RV_OPC_OP: begin
        if (f3 == 3'd0 || f3 == 3'd5)
          ok = (f7 == 7'h00) || (f7 == 7'h20);
        else
          ok = (f7 == 7'h00);
        c.rd_wen = 1'b1;
        c.alu_op = arith_op(f3, f7 == 7'h20);
      end
      `RV_OPC_SYSTEM: begin
        if (f3 >= 3'd1 && f3 <= 3'd3) begin
          c.wb_src   = rv_decode_pkg::csr_old;
          c.rd_wen   = 1'b1;
          c.csr_inst = 1'b1;
          if (f3 != 3'd1) begin
            c.alu_op  = (f3 == 3'd2) ? rv_decode_pkg::csr_set : rv_decode_pkg::csr_clear;
            c.op2_src = rv_decode_pkg::csr;
          end
        end else begin
          ok        = (w == 32'h00000073) || (w == 32'h30200073) || (w == 32'h00100073);
          c.is_ecall = (w == 32'h00000073);
          c.is_mret  = (w == 32'h30200073);
        end
      end
      `RV_OPC_MISC_MEM: begin
        ok           = (f3 == 3'd1);
        c.is_fence_i = 1'b1;
      end
      default: ok = 1'b0;
    endcase
    if (!ok)
      return '0;
    c.rs1      = (w[6:0] == `RV_OPC_LUI) ? 5'd0 : w[19:15];
    c.rs2      = (c.csr_inst && f3 == 3'd1) ? 5'd0 : w[24:20];
    c.rd       = c.rd_wen ? w[11:7] : 5'd0;
    c.csr_addr = c.csr_inst ? w[31:20] : 12'd0;
    return c;
  endfunction

  function automatic logic [31:0] predict_imm(input logic [31:0] w);
    if (predict_ctrl(w) == '0)
      return 32'd0;
    case (w[6:0])
      `RV_OPC_LUI, `RV_OPC_AUIPC: return {w[31:12], 12'd0};
      `RV_OPC_JAL:    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      `RV_OPC_BRANCH: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      `RV_OPC_STORE:  return {{20{w[31]}}, w[31:25], w[11:7]};
      `RV_OPC_JALR, `RV_OPC_LOAD, `RV_OPC_OP_IMM: return {{20{w[31]}}, w[31:20]};
      `RV_OPC_SYSTEM: return (w[14:12] != 3'd0) ? {{20{w[31]}}, w[31:20]} : 32'd0;
      default:        return 32'd0;
    endcase
  endfunction

  function automatic logic pulses(input logic [31:0] w);
    rv_decode_pkg::decode_ctrl_t c;
    c = predict_ctrl(w);
    return c.is_ecall || c.is_mret || c.is_fence_i;
  endfunction

  function automatic logic model_ready();
    rv_decode_pkg::decode_ctrl_t c;
    c = predict_ctrl(m_inst);
    return !(c.mem.ren && c.rd != 0 && (inst[19:15] == c.rd || inst[24:20] == c.rd));
  endfunction

  // registers are kept to x0..x7 and csr addresses to 0x300..0x303
  // so that dependences are frequent
  function logic [31:0] gen_word(input int t);
    logic [31:0] r;
    logic [31:0] w;
    logic [6:0]  f7;
    int          k;
    r  = rand32();
    k  = (rand32() % 100 < p_load[t]) ? 5 : int'(rand32() % 13);
    f7 = (r[1:0] == 2'd0) ? r[31:25] : (r[2] ? 7'h20 : 7'h00);
    w  = {f7, 2'b0, r[5:3], 2'b0, r[8:6], r[14:12], 2'b0, r[11:9], 7'd0};
    case (k)
      0:  w = {r[31:12], w[11:7], `RV_OPC_LUI};
      1:  w = {r[31:12], w[11:7], `RV_OPC_AUIPC};
      2:  w = {r[31:12], w[11:7], `RV_OPC_JAL};
      3:  w[6:0] = `RV_OPC_JALR;
      4:  w[6:0] = `RV_OPC_BRANCH;
      5:  w[6:0] = `RV_OPC_LOAD;
      6:  w[6:0] = `RV_OPC_STORE;
      7:  w[6:0] = `RV_OPC_OP_IMM;
      8:  w[6:0] = `RV_OPC_OP;
      9:  w = {10'h0c0, r[21:20], w[19:15], 3'(1 + r[13:12] % 3), w[11:7], `RV_OPC_SYSTEM};
      10: w = (r[13:12] == 2'd0) ? 32'h00100073 : (r[12] ? 32'h30200073 : 32'h00000073);
      11: w = {w[31:15], 3'd1, w[11:7], `RV_OPC_MISC_MEM};
      default: w = rand32();
    endcase
    // no two system words back to back, so every pulse stands alone
    if (pulses(w) && pulses(m_inst))
      w = 32'h00000033;
    return w;
  endfunction

  // one clock edge: advance the model on the pre-edge inputs, then drive new ones
  task automatic step(input int t);
    rv_decode_pkg::decode_ctrl_t c;
    logic cap;
    @(posedge clock);
    c   = predict_ctrl(m_inst);
    cap = inst_valid && model_ready() && !block && !clear_pipeline;
    if (reset || clear_pipeline) begin
      m_inst     = '0;
      m_valid    = 1'b0;
      m_mem      = '0;
      m_sys1     = '0;
      m_sys2     = '0;
      m_ex.rd_wen  = 1'b0;
      m_ex.csr_wen = 1'b0;
      m_ls.rd_wen  = 1'b0;
      m_ls.csr_wen = 1'b0;
    end else if (!block) begin
      m_ls    = m_ex;
      m_ex    = {c.rd, c.rd_wen, c.csr_addr, c.csr_inst};
      m_sys2  = m_sys1;
      m_sys1  = {c.is_ecall, c.is_mret, c.is_fence_i};
      m_mem   = c.mem;
      m_valid = cap;
      m_inst  = cap ? inst : '0;
    end
    if (!block) begin
      m_pc_out = m_pc_q;
      m_pc_q   = pc;
    end
    inst           <= gen_word(t);
    pc             <= rand32() & 32'hffff_fffc;
    inst_valid     <= (rand32() % 100) < 85;
    block          <= (rand32() % 100) < p_block[t];
    clear_pipeline <= (rand32() % 100) < p_clear[t];
  endtask

  task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_outputs();
    rv_decode_pkg::decode_ctrl_t c;
    rv_decode_pkg::fwd_sel_t     f1;
    rv_decode_pkg::fwd_sel_t     f2;
    rv_decode_pkg::fwd_sel_t     fc;
    @(negedge clock);
    c  = predict_ctrl(m_inst);
    f1 = {m_ex.rd_wen && m_ex.rd != 0 && c.rs1 == m_ex.rd,
          m_ls.rd_wen && m_ls.rd != 0 && c.rs1 == m_ls.rd};
    f2 = {m_ex.rd_wen && m_ex.rd != 0 && c.rs2 == m_ex.rd,
          m_ls.rd_wen && m_ls.rd != 0 && c.rs2 == m_ls.rd};
    fc = {c.csr_inst && m_ex.csr_wen && c.csr_addr == m_ex.csr,
          c.csr_inst && m_ls.csr_wen && c.csr_addr == m_ls.csr};
    if (!ready && inst_valid)
      stalls++;
    compare("ctrl_out", ctrl_out, c);
    compare("imm", imm, predict_imm(m_inst));
    compare("decode_valid", decode_valid, m_valid);
    compare("fwd_rs1", fwd_rs1, f1);
    compare("fwd_rs2", fwd_rs2, f2);
    compare("fwd_csr", fwd_csr, fc);
    compare("ready", ready, model_ready());
    compare("mem", mem, m_mem);
    compare("pc_out", pc_out, m_pc_out);
    compare("wb_rd", {wb_rd, wb_rd_wen}, {m_ls.rd, m_ls.rd_wen});
    compare("wb_csr", {wb_csr, wb_csr_wen}, {m_ls.csr, m_ls.csr_wen});
    compare("system pulses", {ecall, mret, fence_i}, m_sys2);
  endtask

  initial begin
    int last_errors;
    seed           = 32'h23cddf2d;
    errors         = 0;
    checks         = 0;
    stalls         = 0;
    reset          = 1'b1;
    inst           = '0;
    pc             = '0;
    inst_valid     = 1'b0;
    block          = 1'b0;
    clear_pipeline = 1'b0;
    m_inst         = '0;
    m_ex           = 'x;
    m_ls           = 'x;
    m_pc_q         = 'x;
    m_pc_out       = 'x;
    repeat (3)
      step(0);
    step(0);
    reset <= 1'b0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      last_errors = errors;
      stalls      = 0;
      for (int n = 0; n < TEST_CYCLES; n++) begin
        step(t);
        check_outputs();
      end
      $display("test %0d done: %0d errors, %0d load-use stalls", t, errors - last_errors,
               stalls);
    end
    $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+logic
logic/rv_decode_pkg.sv
logic/imm_gen.sv
logic/inst_field_decoder.sv
logic/hazard_tracker.sv
logic/decode_stage.sv
logic/decode_top.sv
tests/decode_asserts.sv
tests/decode_tb.sv
